// File: design/lnorm_config.svh
`ifndef LNORM_CONFIG_SVH
`define LNORM_CONFIG_SVH

// lanes carried by one input or output beat
`define LNORM_LANES 8

// bits per signed sample
`define LNORM_LANE_W 8

// frame buffer depth in beats, enough for 768 samples
`define LNORM_MAX_BEATS 96

// registered levels in a sum tree, log2 of the lane count
`define LNORM_TREE_STAGES 3

`endif

// File: design/lnorm_pkg.sv
`include "lnorm_config.svh"

package lnorm_pkg;

    // one signed sample and one beat of samples
    typedef logic signed [`LNORM_LANE_W-1:0] lane_t;
    typedef lane_t [`LNORM_LANES-1:0] bus_t;

    // squared samples, never above 128*128 so the sign bit stays clear
    typedef logic signed [2*`LNORM_LANE_W-1:0] sq_t;
    typedef sq_t [`LNORM_LANES-1:0] sq_bus_t;

    // frame accumulators
    typedef logic signed [23:0] sum_t;
    typedef logic [31:0] sq_sum_t;

    typedef logic [15:0] var_t;
    typedef logic [9:0] count_t;
    typedef logic [6:0] beat_t;
    typedef logic [4:0] shift_t;

    // frame setup, latched from the count and shift strobes
    typedef struct packed {
        count_t count;
        beat_t  beats;
        shift_t shift;
    } frame_cfg_t;

    typedef struct packed {
        lane_t mean;
        var_t  variance;
    } lnorm_stats_t;

    typedef enum logic [1:0] {
        st_setup,
        st_gather,
        st_reduce,
        st_stream
    } frame_state_t;

endpackage

// File: design/lnorm_sum_tree.sv
`timescale 1ns/100ps

`include "lnorm_config.svh"

module lnorm_sum_tree #(
    parameter int IN_W  = 8,
    parameter int OUT_W = 24
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic [`LNORM_LANES*IN_W-1:0] lanes,
    input  logic                         lanes_vld,
    output logic [OUT_W-1:0]             total,
    output logic                         total_vld
);

    localparam int LANES  = `LNORM_LANES;
    localparam int STAGES = `LNORM_TREE_STAGES;
    localparam int NODES  = LANES - 1;

    logic signed [OUT_W-1:0] leaf [LANES];
    // heap order, node n adds children 2n+1 and 2n+2
    logic signed [OUT_W-1:0] node [NODES];
    logic [STAGES-1:0]       vld_sr;

    for (genvar l = 0; l < LANES; l++) begin : g_leaf
        assign leaf[l] = $signed(lanes[l*IN_W +: IN_W]);
    end

    for (genvar n = 0; n < NODES; n++) begin : g_node
        localparam int A = 2*n + 1;
        localparam int B = 2*n + 2;
        logic signed [OUT_W-1:0] a_in;
        logic signed [OUT_W-1:0] b_in;

        // children past the last inner node are the lane inputs
        if (A >= NODES) begin : g_a_leaf
            assign a_in = leaf[A-NODES];
        end else begin : g_a_node
            assign a_in = node[A];
        end
        if (B >= NODES) begin : g_b_leaf
            assign b_in = leaf[B-NODES];
        end else begin : g_b_node
            assign b_in = node[B];
        end

        always_ff @(posedge clk) begin
            node[n] <= a_in + b_in;
        end
    end

    // one valid bit per tree level
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= (vld_sr << 1) | STAGES'(lanes_vld);
        end
    end

    assign total     = node[0];
    assign total_vld = vld_sr[STAGES-1];

endmodule

// File: design/lnorm_ingest.sv
`timescale 1ns/100ps

`include "lnorm_config.svh"

module lnorm_ingest (
    input  logic                    clk,
    input  logic                    rstn,
    input  lnorm_pkg::count_t       in_num,
    input  logic                    in_num_vld,
    input  lnorm_pkg::shift_t       in_shift,
    input  logic                    in_shift_vld,
    input  lnorm_pkg::bus_t         in_data,
    input  logic                    in_data_vld,
    input  logic                    stats_vld,
    input  logic                    stream_done,
    output lnorm_pkg::frame_cfg_t   cfg,
    output lnorm_pkg::bus_t         beat,
    output logic                    beat_vld,
    output lnorm_pkg::frame_state_t state
);

    lnorm_pkg::frame_state_t next_state;
    lnorm_pkg::beat_t        beat_cnt;
    logic                    accept;
    logic                    last_in;

    // beats are taken only while gathering a frame
    assign accept  = in_data_vld && (state == lnorm_pkg::st_gather);
    assign last_in = accept && (beat_cnt == cfg.beats - 1'b1);

    always_comb begin
        next_state = state;
        case (state)
            lnorm_pkg::st_setup: begin
                if (in_num_vld) begin
                    next_state = lnorm_pkg::st_gather;
                end
            end
            lnorm_pkg::st_gather: begin
                if (last_in) begin
                    next_state = lnorm_pkg::st_reduce;
                end
            end
            lnorm_pkg::st_reduce: begin
                if (stats_vld) begin
                    next_state = lnorm_pkg::st_stream;
                end
            end
            lnorm_pkg::st_stream: begin
                if (stream_done) begin
                    next_state = lnorm_pkg::st_setup;
                end
            end
            default: next_state = lnorm_pkg::st_setup;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= lnorm_pkg::st_setup;
            beat_cnt <= '0;
            beat_vld <= 1'b0;
        end else begin
            state    <= next_state;
            beat_vld <= accept;
            if (state == lnorm_pkg::st_setup) begin
                beat_cnt <= '0;
            end else if (accept) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // count and beats only change between frames, shift at any time
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg <= '0;
        end else begin
            if (in_num_vld && (state == lnorm_pkg::st_setup)) begin
                cfg.count <= in_num;
                cfg.beats <= lnorm_pkg::beat_t'(in_num / `LNORM_LANES);
            end
            if (in_shift_vld) begin
                cfg.shift <= in_shift;
            end
        end
    end

    // input register, qualified by beat_vld
    always_ff @(posedge clk) begin
        beat <= in_data;
    end

endmodule

// File: design/lnorm_stats.sv
`timescale 1ns/100ps

module lnorm_stats (
    input  logic                    clk,
    input  logic                    rstn,
    input  lnorm_pkg::frame_cfg_t   cfg,
    input  lnorm_pkg::frame_state_t state,
    input  lnorm_pkg::bus_t         beat,
    input  logic                    beat_vld,
    output lnorm_pkg::lnorm_stats_t stats,
    output logic                    stats_vld
);

    lnorm_pkg::sq_bus_t sq_bus;
    logic               sq_vld;
    lnorm_pkg::sum_t    tree_sum;
    logic               tree_sum_vld;
    lnorm_pkg::sq_sum_t tree_sq;
    logic               tree_sq_vld;
    lnorm_pkg::sum_t    sum_acc;
    lnorm_pkg::sq_sum_t sq_acc;
    lnorm_pkg::beat_t   red_cnt;
    logic               fin;
    lnorm_pkg::sum_t    mean_full;
    lnorm_pkg::sq_sum_t msq_full;
    lnorm_pkg::lane_t   s1_mean;
    lnorm_pkg::var_t    s1_msq;
    logic               s1_vld;
    logic signed [15:0] mean_sq;

    // squares trail the plain samples by one cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < $bits(lnorm_pkg::bus_t) / $bits(lnorm_pkg::lane_t); i++) begin
            sq_bus[i] <= $signed(beat[i]) * $signed(beat[i]);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sq_vld <= 1'b0;
        end else begin
            sq_vld <= beat_vld;
        end
    end

    lnorm_sum_tree #(
        .IN_W  ($bits(lnorm_pkg::lane_t)),
        .OUT_W ($bits(lnorm_pkg::sum_t))
    ) u_sum_tree (
        .clk       (clk),
        .rstn      (rstn),
        .lanes     (beat),
        .lanes_vld (beat_vld),
        .total     (tree_sum),
        .total_vld (tree_sum_vld)
    );

    lnorm_sum_tree #(
        .IN_W  ($bits(lnorm_pkg::sq_t)),
        .OUT_W ($bits(lnorm_pkg::sq_sum_t))
    ) u_sq_tree (
        .clk       (clk),
        .rstn      (rstn),
        .lanes     (sq_bus),
        .lanes_vld (sq_vld),
        .total     (tree_sq),
        .total_vld (tree_sq_vld)
    );

    // frame accumulators, the square side finishes last
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sum_acc <= '0;
            sq_acc  <= '0;
            red_cnt <= '0;
            fin     <= 1'b0;
        end else if (state == lnorm_pkg::st_setup) begin
            sum_acc <= '0;
            sq_acc  <= '0;
            red_cnt <= '0;
            fin     <= 1'b0;
        end else begin
            if (tree_sum_vld) begin
                sum_acc <= sum_acc + tree_sum;
            end
            if (tree_sq_vld) begin
                sq_acc  <= sq_acc + tree_sq;
                red_cnt <= red_cnt + 1'b1;
            end
            fin <= tree_sq_vld && (red_cnt == cfg.beats - 1'b1);
        end
    end

    // signed division truncates toward zero
    assign mean_full = sum_acc / $signed({1'b0, cfg.count});
    assign msq_full  = (sq_acc / cfg.count) >> cfg.shift;
    assign mean_sq   = s1_mean * s1_mean;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_vld    <= 1'b0;
            stats_vld <= 1'b0;
        end else begin
            s1_vld    <= fin;
            stats_vld <= s1_vld;
        end
    end

    // results hold until the next frame finishes
    always_ff @(posedge clk) begin
        if (fin) begin
            s1_mean <= lnorm_pkg::lane_t'(mean_full);
            s1_msq  <= lnorm_pkg::var_t'(msq_full);
        end
        if (s1_vld) begin
            stats.mean     <= s1_mean;
            stats.variance <= s1_msq - mean_sq;
        end
    end

endmodule

// File: design/lnorm_frame_buf.sv
`timescale 1ns/100ps

`include "lnorm_config.svh"

module lnorm_frame_buf (
    input  logic            clk,
    input  logic            rstn,
    input  logic            wr,
    input  lnorm_pkg::bus_t din,
    input  logic            rd,
    output lnorm_pkg::bus_t dout
);

    localparam lnorm_pkg::beat_t LAST_ADDR = lnorm_pkg::beat_t'(`LNORM_MAX_BEATS - 1);

    lnorm_pkg::bus_t  mem [`LNORM_MAX_BEATS];
    lnorm_pkg::beat_t wr_ptr;
    lnorm_pkg::beat_t rd_ptr;

    // both pointers wrap at the buffer depth
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= din;
        end
        // registered read, data one cycle after rd
        if (rd) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

// File: design/lnorm_emit.sv
`timescale 1ns/100ps

module lnorm_emit (
    input  logic                    clk,
    input  logic                    rstn,
    input  lnorm_pkg::frame_cfg_t   cfg,
    input  lnorm_pkg::lnorm_stats_t stats,
    input  logic                    stats_vld,
    input  lnorm_pkg::bus_t         dout,
    output logic                    rd,
    output logic                    stream_done,
    output lnorm_pkg::bus_t         out_data,
    output logic                    out_vld,
    output logic                    out_last
);

    lnorm_pkg::beat_t rd_left;
    lnorm_pkg::lane_t mean_q;
    logic             rd_last;
    logic             dout_vld;
    logic             dout_last;

    // reads run back to back from the cycle after stats_vld
    assign rd      = (rd_left != '0);
    assign rd_last = (rd_left == lnorm_pkg::beat_t'(1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_left   <= '0;
            dout_vld  <= 1'b0;
            dout_last <= 1'b0;
            out_vld   <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            if (stats_vld) begin
                rd_left <= cfg.beats;
            end else if (rd) begin
                rd_left <= rd_left - 1'b1;
            end
            dout_vld  <= rd;
            dout_last <= rd_last;
            out_vld   <= dout_vld;
            out_last  <= dout_last;
        end
    end

    always_ff @(posedge clk) begin
        if (stats_vld) begin
            mean_q <= stats.mean;
        end
        // centering wraps each lane to 8 bits
        for (int i = 0; i < $bits(lnorm_pkg::bus_t) / $bits(lnorm_pkg::lane_t); i++) begin
            out_data[i] <= dout[i] - mean_q;
        end
    end

    // frame ends with the final beat on the output
    assign stream_done = out_last;

endmodule

// File: design/lnorm_top.sv
`timescale 1ns/100ps

module lnorm_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  lnorm_pkg::count_t     in_num,
    input  logic                  in_num_vld,
    input  lnorm_pkg::shift_t     in_shift,
    input  logic                  in_shift_vld,
    input  lnorm_pkg::bus_t       in_data,
    input  logic                  in_data_vld,
    output lnorm_pkg::var_t       out_var,
    output logic                  out_var_vld,
    output lnorm_pkg::bus_t       out_data,
    output logic                  out_vld,
    output logic                  out_last
);

    lnorm_pkg::frame_cfg_t   cfg;
    lnorm_pkg::frame_state_t state;
    lnorm_pkg::bus_t         beat;
    logic                    beat_vld;
    lnorm_pkg::lnorm_stats_t stats;
    logic                    stats_vld;
    lnorm_pkg::bus_t         buf_dout;
    logic                    rd;
    logic                    stream_done;

    lnorm_ingest u_ingest (
        .clk          (clk),
        .rstn         (rstn),
        .in_num       (in_num),
        .in_num_vld   (in_num_vld),
        .in_shift     (in_shift),
        .in_shift_vld (in_shift_vld),
        .in_data      (in_data),
        .in_data_vld  (in_data_vld),
        .stats_vld    (stats_vld),
        .stream_done  (stream_done),
        .cfg          (cfg),
        .beat         (beat),
        .beat_vld     (beat_vld),
        .state        (state)
    );

    lnorm_stats u_stats (
        .clk       (clk),
        .rstn      (rstn),
        .cfg       (cfg),
        .state     (state),
        .beat      (beat),
        .beat_vld  (beat_vld),
        .stats     (stats),
        .stats_vld (stats_vld)
    );

    // the registered beat is written in the same cycle the stats see it
    lnorm_frame_buf u_frame_buf (
        .clk  (clk),
        .rstn (rstn),
        .wr   (beat_vld),
        .din  (beat),
        .rd   (rd),
        .dout (buf_dout)
    );

    lnorm_emit u_emit (
        .clk         (clk),
        .rstn        (rstn),
        .cfg         (cfg),
        .stats       (stats),
        .stats_vld   (stats_vld),
        .dout        (buf_dout),
        .rd          (rd),
        .stream_done (stream_done),
        .out_data    (out_data),
        .out_vld     (out_vld),
        .out_last    (out_last)
    );

    assign out_var     = stats.variance;
    assign out_var_vld = stats_vld;

endmodule

// File: sim/lnorm_assert.sv
`timescale 1ns/100ps

module lnorm_assert (
    input logic clk,
    input logic rstn,
    input logic in_num_vld,
    input logic out_var_vld,
    input logic out_vld,
    input logic out_last
);

    // read by the testbench to catch any failed check here
    int   fail_cnt = 0;
    logic num_seen;

    // set by the first count strobe after reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            num_seen <= 1'b0;
        end else if (in_num_vld) begin
            num_seen <= 1'b1;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        !num_seen |-> !out_vld && !out_last && !out_var_vld)
        else begin
            $error("output active before the first count strobe");
            fail_cnt++;
        end

    a_last_needs_vld: assert property (@(posedge clk) disable iff (!rstn)
        out_last |-> out_vld)
        else begin
            $error("out_last without out_vld");
            fail_cnt++;
        end

    // the stream of a frame never overlaps its own statistics
    a_var_outside_stream: assert property (@(posedge clk) disable iff (!rstn)
        out_var_vld |-> !out_vld)
        else begin
            $error("out_var_vld during the output stream");
            fail_cnt++;
        end

endmodule

bind lnorm_top lnorm_assert u_lnorm_assert (
    .clk         (clk),
    .rstn        (rstn),
    .in_num_vld  (in_num_vld),
    .out_var_vld (out_var_vld),
    .out_vld     (out_vld),
    .out_last    (out_last)
);

// File: sim/tb_lnorm.sv
`timescale 1ns/100ps

`include "lnorm_config.svh"

module tb_lnorm;

    localparam int TOTAL_SAMPLES = 16 + 64 + 256;
    localparam int CYCLE_LIMIT   = 4 * TOTAL_SAMPLES + 200;

    logic                  clk = 1'b0;
    logic                  rstn;
    lnorm_pkg::count_t     in_num;
    logic                  in_num_vld;
    lnorm_pkg::shift_t     in_shift;
    logic                  in_shift_vld;
    lnorm_pkg::bus_t       in_data;
    logic                  in_data_vld;
    lnorm_pkg::var_t       out_var;
    logic                  out_var_vld;
    lnorm_pkg::bus_t       out_data;
    logic                  out_vld;
    logic                  out_last;

    // expected results, filled by the model as frames are sent
    lnorm_pkg::bus_t exp_q [$];
    lnorm_pkg::var_t exp_var_q [$];
    int              len_q [$];
    lnorm_pkg::bus_t exp_beat;
    lnorm_pkg::var_t exp_var;
    logic [31:0]     rng = 32'd40;
    int              cycles = 0;
    int              var_seen = 0;
    int              frames_done = 0;
    int              run_cnt = 0;
    int              run_len = 0;

    lnorm_top UUT (
        .clk          (clk),
        .rstn         (rstn),
        .in_num       (in_num),
        .in_num_vld   (in_num_vld),
        .in_shift     (in_shift),
        .in_shift_vld (in_shift_vld),
        .in_data      (in_data),
        .in_data_vld  (in_data_vld),
        .out_var      (out_var),
        .out_var_vld  (out_var_vld),
        .out_data     (out_data),
        .out_vld      (out_vld),
        .out_last     (out_last)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic finish_failed();
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic flag_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        finish_failed();
    endtask

    task automatic abort_run(input string msg);
        $display("%0t: %s", $time, msg);
        finish_failed();
    endtask

    // builds one frame, queues its model results, drives it and waits for its end
    task automatic send_frame(input int count, input int shift);
        lnorm_pkg::bus_t  beats [$];
        lnorm_pkg::bus_t  b;
        lnorm_pkg::bus_t  c;
        lnorm_pkg::lane_t mean8;
        int               sum;
        int               sq_sum;
        int               msq;
        int               gap;
        int               target;
        sum    = 0;
        sq_sum = 0;
        target = frames_done + 1;
        for (int i = 0; i < count / `LNORM_LANES; i++) begin
            for (int l = 0; l < `LNORM_LANES; l++) begin
                rng  = xorshift32(rng);
                b[l] = lnorm_pkg::lane_t'(int'(rng[6:0]) - 64);
                sum    += int'(b[l]);
                sq_sum += int'(b[l]) * int'(b[l]);
            end
            beats.push_back(b);
        end
        // integer division truncates toward zero
        mean8 = lnorm_pkg::lane_t'(sum / count);
        msq   = (sq_sum / count) >> shift;
        exp_var_q.push_back(lnorm_pkg::var_t'(msq - int'(mean8) * int'(mean8)));
        len_q.push_back(count / `LNORM_LANES);
        foreach (beats[i]) begin
            for (int l = 0; l < `LNORM_LANES; l++) begin
                c[l] = lnorm_pkg::lane_t'(int'(beats[i][l]) - int'(mean8));
            end
            exp_q.push_back(c);
        end

        @(negedge clk);
        in_num       = lnorm_pkg::count_t'(count);
        in_num_vld   = 1'b1;
        in_shift     = lnorm_pkg::shift_t'(shift);
        in_shift_vld = 1'b1;
        @(negedge clk);
        in_num_vld   = 1'b0;
        in_shift_vld = 1'b0;
        foreach (beats[i]) begin
            rng = xorshift32(rng);
            gap = int'(rng[1:0]);
            in_data_vld = 1'b0;
            repeat (gap) @(negedge clk);
            in_data     = beats[i];
            in_data_vld = 1'b1;
            @(negedge clk);
        end
        in_data_vld = 1'b0;
        wait (frames_done == target);
        repeat (2) @(negedge clk);
    endtask

    initial begin
        rstn         = 1'b0;
        in_num       = '0;
        in_num_vld   = 1'b0;
        in_shift     = '0;
        in_shift_vld = 1'b0;
        in_data      = '0;
        in_data_vld  = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        repeat (2) @(negedge clk);

        send_frame(16, 0);
        send_frame(64, 0);
        send_frame(256, 2);

        if (exp_q.size() == 0 && exp_var_q.size() == 0 && var_seen == 3) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("frames ended with results still missing");
        end
    end

    // output checks, sampled on the falling edge where outputs are stable
    always @(negedge clk) begin
        if (rstn) begin
            if (UUT.u_lnorm_assert.fail_cnt != 0) begin
                abort_run("a bound assertion on the DUT outputs failed");
            end
            if (out_var_vld) begin
                assert (exp_var_q.size() != 0)
                    else abort_run("out_var_vld pulsed with no frame pending");
                exp_var = exp_var_q.pop_front();
                assert (out_var == exp_var)
                    else flag_mismatch($sformatf("out_var %0d, expected %0d", out_var, exp_var));
                var_seen++;
            end
            if (out_vld) begin
                if (run_cnt == 0) begin
                    assert (len_q.size() != 0)
                        else abort_run("out_vld rose with no frame pending");
                    run_len = len_q.pop_front();
                end
                assert (exp_q.size() != 0)
                    else abort_run("more output beats than were sent");
                exp_beat = exp_q.pop_front();
                assert (out_data == exp_beat)
                    else flag_mismatch($sformatf("out_data %h, expected %h", out_data, exp_beat));
                assert (out_last == (run_cnt == run_len - 1))
                    else flag_mismatch($sformatf("out_last %b on beat %0d of %0d",
                        out_last, run_cnt + 1, run_len));
                run_cnt++;
                if (out_last) begin
                    assert (var_seen == frames_done + 1)
                        else abort_run("frame did not carry exactly one out_var_vld pulse");
                    run_cnt = 0;
                    frames_done++;
                end
            end
        end
    end

    a_var_pulse: assert property (@(posedge clk) disable iff (!rstn)
        out_var_vld |=> !out_var_vld)
        else abort_run("out_var_vld stayed high for more than one cycle");

    a_stream_start: assert property (@(posedge clk) disable iff (!rstn)
        out_var_vld |=> !out_vld ##1 !out_vld ##1 out_vld)
        else abort_run("out_vld did not start exactly 3 cycles after out_var_vld");

    a_stream_run: assert property (@(posedge clk) disable iff (!rstn)
        out_vld && !out_last |=> out_vld)
        else abort_run("out_vld dropped before out_last");

    // run limit from the total sample count
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            abort_run($sformatf("run timed out after %0d cycles", cycles));
        end
    end

endmodule

// File: compile.f
+incdir+design
design/lnorm_pkg.sv
design/lnorm_sum_tree.sv
design/lnorm_ingest.sv
design/lnorm_stats.sv
design/lnorm_frame_buf.sv
design/lnorm_emit.sv
design/lnorm_top.sv
sim/lnorm_assert.sv
sim/tb_lnorm.sv

// File: Bender.yml
package:
  name: lnorm

export_include_dirs:
  - design

sources:
  - design/lnorm_pkg.sv
  - design/lnorm_sum_tree.sv
  - design/lnorm_ingest.sv
  - design/lnorm_stats.sv
  - design/lnorm_frame_buf.sv
  - design/lnorm_emit.sv
  - design/lnorm_top.sv
  - target: simulation
    files:
      - sim/lnorm_assert.sv
      - sim/tb_lnorm.sv
